// File: include/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Word width of data, addresses and instructions
`define XLEN 32

// Register file address width
`define REG_AW 5

// addi x0,x0,0 fills the instr field of a bubble
`define NOP_INSTR 32'h0000_0013

// Encoded widths of the ALU operation and exception cause
`define ALU_OP_W 4
`define CAUSE_W 4

`endif

// File: source/decode_pkg.sv
`default_nettype none
`include "decode_params.svh"

package decode_pkg;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_t;

  typedef enum logic [`ALU_OP_W-1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B // Forwards the immediate for lui
  } alu_op_t;

  // Values follow the machine mcause encoding
  typedef enum logic [`CAUSE_W-1:0] {
    EXC_NONE       = 4'd0,
    EXC_ILLEGAL    = 4'd2,
    EXC_BREAKPOINT = 4'd3,
    EXC_ECALL_M    = 4'd11
  } exc_cause_t;

  typedef struct packed {
    logic valid;
    logic wren;
    logic rden1;
    logic rden2;
    logic load;
    logic store;
    logic branch;
    logic jal;
    logic jalr;
    logic lui;
    logic auipc;
    logic ecall;
    logic ebreak;
    logic fence;
    logic exception;
  } op_flags_t;

  // One slot as handed to execute
  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   instr;
    logic [`REG_AW-1:0] waddr;
    logic [`REG_AW-1:0] raddr1;
    logic [`REG_AW-1:0] raddr2;
    logic [`XLEN-1:0]   imm;
    op_flags_t          op;
    alu_op_t            alu_op;
    exc_cause_t         ecause;
  } decoded_t;

endpackage

`default_nettype wire

// File: source/decoder_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_params.svh"

interface decoder_if import decode_pkg::*; ();

  logic [`XLEN-1:0] instr;
  logic             valid;    // Legal encoding for this decoder's subset
  op_flags_t        flags;
  logic [`XLEN-1:0] imm;
  alu_op_t          alu_op;
  logic             basic_ok; // OP, OP-IMM, LUI or AUIPC

  modport stage_mp (
    output instr,
    input  valid,
    input  flags,
    input  imm,
    input  alu_op,
    input  basic_ok
  );

  modport decoder_mp (
    input  instr,
    output valid,
    output flags,
    output imm,
    output alu_op,
    output basic_ok
  );

endinterface

`default_nettype wire

// File: source/int_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_params.svh"

module int_decoder import decode_pkg::*; #(
  parameter bit full = 1'b1 // Cleared for a slot that only takes the basic ALU classes
) (
  decoder_if.decoder_mp bus
);

  logic [`XLEN-1:0] instr;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm;
  op_flags_t        flags;
  alu_op_t          alu_op;
  logic             legal;
  logic             basic;
  logic             valid_out;

  // funct3 mapping shared by OP and OP-IMM, alt is instr[30]
  function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign instr  = bus.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    flags  = '0;
    legal  = 1'b0;
    basic  = 1'b0;
    imm    = '0;
    alu_op = ALU_ADD;
    case (opcode)
      OPC_LUI: begin
        {legal, basic, flags.wren, flags.lui} = 4'b1111;
        imm    = imm_u;
        alu_op = ALU_PASS_B;
      end
      OPC_AUIPC: begin
        {legal, basic, flags.wren, flags.auipc} = 4'b1111;
        imm = imm_u;
      end
      OPC_JAL: begin
        {legal, flags.wren, flags.jal} = 3'b111;
        imm = imm_j;
      end
      OPC_JALR: begin
        legal = (funct3 == 3'b000);
        {flags.wren, flags.rden1, flags.jalr} = 3'b111;
        imm = imm_i;
      end
      OPC_BRANCH: begin
        legal = (funct3[2:1] != 2'b01);
        {flags.rden1, flags.rden2, flags.branch} = 3'b111;
        imm = imm_b;
        alu_op = (funct3[2:1] == 2'b00) ? ALU_SUB : (funct3[1] ? ALU_SLTU : ALU_SLT);
      end
      OPC_LOAD: begin
        legal = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
        {flags.wren, flags.rden1, flags.load} = 3'b111;
        imm = imm_i;
      end
      OPC_STORE: begin
        legal = (funct3[2] == 1'b0) && (funct3 != 3'b011);
        {flags.rden1, flags.rden2, flags.store} = 3'b111;
        imm = imm_s;
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b001) begin
          legal = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          legal = 1'b1;
        end
        {basic, flags.wren, flags.rden1} = 3'b111;
        imm    = imm_i;
        alu_op = funct_to_alu(funct3, (funct3 == 3'b101) && funct7[5]);
      end
      OPC_OP: begin
        legal = (funct7 == 7'b0000000) ||
                ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
        {basic, flags.wren, flags.rden1, flags.rden2} = 4'b1111;
        alu_op = funct_to_alu(funct3, funct7[5]);
      end
      OPC_MISC_MEM: begin
        legal       = (funct3 == 3'b000);
        flags.fence = 1'b1;
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b000 && instr[19:7] == '0) begin
          flags.ecall  = (instr[31:20] == 12'h000);
          flags.ebreak = (instr[31:20] == 12'h001);
          legal        = flags.ecall || flags.ebreak;
        end
      end
      default: legal = 1'b0;
    endcase
  end

  assign valid_out    = legal && (full || basic);
  assign bus.valid    = valid_out;
  assign bus.basic_ok = legal && basic;
  assign bus.imm      = imm;
  assign bus.alu_op   = alu_op;

  always_comb begin
    bus.flags = '0; // Nothing leaks out of an encoding this slot cannot take
    if (valid_out) begin
      bus.flags       = flags;
      bus.flags.valid = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_params.svh"

module hazard_unit (
  input  logic              rden0_1,
  input  logic              rden0_2,
  input  logic [`REG_AW-1:0] raddr0_1,
  input  logic [`REG_AW-1:0] raddr0_2,
  input  logic              rden1_1,
  input  logic              rden1_2,
  input  logic [`REG_AW-1:0] raddr1_1,
  input  logic [`REG_AW-1:0] raddr1_2,
  input  logic              wren0,
  input  logic [`REG_AW-1:0] waddr0,
  input  logic              basic1,
  input  logic              ex_load,
  input  logic [`REG_AW-1:0] ex_waddr,
  input  logic              ex_stall,
  input  logic              flush,
  output logic              stall,
  output logic              split
);

  logic load_use0;
  logic load_use1;
  logic pair_raw;

  // x0 never carries a dependency
  function automatic logic reads_reg(
    input logic              en1,
    input logic [`REG_AW-1:0] a1,
    input logic              en2,
    input logic [`REG_AW-1:0] a2,
    input logic [`REG_AW-1:0] target
  );
    return (target != '0) && ((en1 && a1 == target) || (en2 && a2 == target));
  endfunction

  assign load_use0 = ex_load && reads_reg(rden0_1, raddr0_1, rden0_2, raddr0_2, ex_waddr);
  assign load_use1 = ex_load && reads_reg(rden1_1, raddr1_1, rden1_2, raddr1_2, ex_waddr);

  // Slot 1 would read a result that slot 0 produces in the same cycle
  assign pair_raw = wren0 && reads_reg(rden1_1, raddr1_1, rden1_2, raddr1_2, waddr0);

  assign stall = !flush && (load_use0 || load_use1 || ex_stall);

  // Fetch holds the whole pair on a stall, so a replay request would be ambiguous
  assign split = !flush && !stall && (!basic1 || pair_raw);

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_params.svh"

module decode_stage import decode_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  input  logic [`XLEN-1:0]   pc0,
  input  logic [`XLEN-1:0]   instr0,
  input  logic [`XLEN-1:0]   pc1,
  input  logic [`XLEN-1:0]   instr1,
  input  logic               pair_valid,
  input  logic               ex_load,
  input  logic [`REG_AW-1:0] ex_waddr,
  input  logic               ex_stall,
  input  logic               flush,
  decoder_if.stage_mp        dec0_bus,
  decoder_if.stage_mp        dec1_bus,
  output decoded_t           slot0,
  output decoded_t           slot1,
  output logic               stall,
  output logic               split
);

  decoded_t s0;
  decoded_t s1;
  logic     hz_split;

  function automatic decoded_t assemble(
    input logic [`XLEN-1:0] pc,
    input logic [`XLEN-1:0] instr,
    input op_flags_t        flags,
    input logic [`XLEN-1:0] imm,
    input alu_op_t          alu_op
  );
    decoded_t d;
    d        = '0;
    d.pc     = pc;
    d.instr  = instr;
    d.waddr  = instr[11:7];
    d.raddr1 = instr[19:15];
    d.raddr2 = instr[24:20];
    d.imm    = imm;
    d.op     = flags;
    d.alu_op = alu_op;
    d.ecause = EXC_NONE;
    return d;
  endfunction

  function automatic decoded_t bubble(input logic [`XLEN-1:0] pc);
    decoded_t d;
    d        = '0;
    d.pc     = pc;
    d.instr  = `NOP_INSTR;
    d.alu_op = ALU_ADD;
    d.ecause = EXC_NONE;
    return d;
  endfunction

  assign dec0_bus.instr = instr0;
  assign dec1_bus.instr = instr1;

  hazard_unit u_hazard (
    .rden0_1  (dec0_bus.flags.rden1 && pair_valid),
    .rden0_2  (dec0_bus.flags.rden2 && pair_valid),
    .raddr0_1 (instr0[19:15]),
    .raddr0_2 (instr0[24:20]),
    .rden1_1  (dec1_bus.flags.rden1 && pair_valid),
    .rden1_2  (dec1_bus.flags.rden2 && pair_valid),
    .raddr1_1 (instr1[19:15]),
    .raddr1_2 (instr1[24:20]),
    .wren0    (dec0_bus.flags.wren),
    .waddr0   (instr0[11:7]),
    .basic1   (dec1_bus.basic_ok),
    .ex_load  (ex_load),
    .ex_waddr (ex_waddr),
    .ex_stall (ex_stall),
    .flush    (flush),
    .stall    (stall),
    .split    (hz_split)
  );

  assign split = hz_split && pair_valid; // No replay without a pair on the inputs

  always_comb begin
    s0 = assemble(pc0, instr0, dec0_bus.flags, dec0_bus.imm, dec0_bus.alu_op);
    s1 = assemble(pc1, instr1, dec1_bus.flags, dec1_bus.imm, dec1_bus.alu_op);
    s0.op.valid = 1'b1; // A trapping slot 0 still goes to execute

    // Illegal outranks ebreak, ebreak outranks ecall
    if (!dec0_bus.valid) begin
      s0.op.exception = 1'b1;
      s0.ecause       = EXC_ILLEGAL;
    end else if (s0.op.ebreak) begin
      s0.op.exception = 1'b1;
      s0.ecause       = EXC_BREAKPOINT;
    end else if (s0.op.ecall) begin
      s0.op.exception = 1'b1;
      s0.ecause       = EXC_ECALL_M;
    end

    if (split || !dec1_bus.valid) begin
      s1 = bubble(pc1);
    end

    if (stall || flush || !pair_valid) begin
      s0 = bubble(pc0);
      s1 = bubble(pc1);
    end
  end

  // Execute back-pressure freezes the register, a flush still clears it
  always_ff @(posedge clock) begin
    if (!reset) begin
      slot0.op     <= '0;
      slot0.ecause <= EXC_NONE;
      slot1.op     <= '0;
      slot1.ecause <= EXC_NONE;
    end else if (flush || !ex_stall) begin
      slot0 <= s0;
      slot1 <= s1;
    end
  end

endmodule

`default_nettype wire

// File: source/decode_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_params.svh"

module decode_top import decode_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  input  logic [`XLEN-1:0]   pc0,
  input  logic [`XLEN-1:0]   instr0,
  input  logic [`XLEN-1:0]   pc1,
  input  logic [`XLEN-1:0]   instr1,
  input  logic               pair_valid,
  input  logic               ex_load,
  input  logic [`REG_AW-1:0] ex_waddr,
  input  logic               ex_stall,
  input  logic               flush,
  output logic               stall,
  output logic               split,
  output logic               dec0_valid,
  output logic [`XLEN-1:0]   dec0_pc,
  output logic [`REG_AW-1:0] dec0_waddr,
  output logic [`REG_AW-1:0] dec0_raddr1,
  output logic [`REG_AW-1:0] dec0_raddr2,
  output logic               dec0_wren,
  output logic               dec0_rden1,
  output logic               dec0_rden2,
  output logic [`XLEN-1:0]   dec0_imm,
  output alu_op_t            dec0_alu_op,
  output logic               dec0_load,
  output logic               dec0_store,
  output logic               dec0_branch,
  output logic               dec0_exception,
  output exc_cause_t         dec0_ecause,
  output logic               dec1_valid,
  output logic [`XLEN-1:0]   dec1_pc,
  output logic [`REG_AW-1:0] dec1_waddr,
  output logic [`REG_AW-1:0] dec1_raddr1,
  output logic [`REG_AW-1:0] dec1_raddr2,
  output logic               dec1_wren,
  output logic               dec1_rden1,
  output logic               dec1_rden2,
  output logic [`XLEN-1:0]   dec1_imm,
  output alu_op_t            dec1_alu_op,
  output logic               dec1_load,
  output logic               dec1_store,
  output logic               dec1_branch
);

  decoded_t slot0;
  decoded_t slot1;

  decoder_if dec0_bus ();
  decoder_if dec1_bus ();

  int_decoder #(.full(1'b1)) u_dec0 (.bus(dec0_bus));
  int_decoder #(.full(1'b0)) u_dec1 (.bus(dec1_bus)); // Slot 1 pairs only ALU work

  decode_stage u_stage (
    .clock      (clock),
    .reset      (reset),
    .pc0        (pc0),
    .instr0     (instr0),
    .pc1        (pc1),
    .instr1     (instr1),
    .pair_valid (pair_valid),
    .ex_load    (ex_load),
    .ex_waddr   (ex_waddr),
    .ex_stall   (ex_stall),
    .flush      (flush),
    .dec0_bus   (dec0_bus),
    .dec1_bus   (dec1_bus),
    .slot0      (slot0),
    .slot1      (slot1),
    .stall      (stall),
    .split      (split)
  );

  assign dec0_valid     = slot0.op.valid;
  assign dec0_pc        = slot0.pc;
  assign dec0_waddr     = slot0.waddr;
  assign dec0_raddr1    = slot0.raddr1;
  assign dec0_raddr2    = slot0.raddr2;
  assign dec0_wren      = slot0.op.wren;
  assign dec0_rden1     = slot0.op.rden1;
  assign dec0_rden2     = slot0.op.rden2;
  assign dec0_imm       = slot0.imm;
  assign dec0_alu_op    = slot0.alu_op;
  assign dec0_load      = slot0.op.load;
  assign dec0_store     = slot0.op.store;
  assign dec0_branch    = slot0.op.branch;
  assign dec0_exception = slot0.op.exception;
  assign dec0_ecause    = slot0.ecause;

  assign dec1_valid  = slot1.op.valid;
  assign dec1_pc     = slot1.pc;
  assign dec1_waddr  = slot1.waddr;
  assign dec1_raddr1 = slot1.raddr1;
  assign dec1_raddr2 = slot1.raddr2;
  assign dec1_wren   = slot1.op.wren;
  assign dec1_rden1  = slot1.op.rden1;
  assign dec1_rden2  = slot1.op.rden2;
  assign dec1_imm    = slot1.imm;
  assign dec1_alu_op = slot1.alu_op;
  assign dec1_load   = slot1.op.load;
  assign dec1_store  = slot1.op.store;
  assign dec1_branch = slot1.op.branch;

endmodule

`default_nettype wire

// File: sim/decode_sva.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_params.svh"

module decode_sva (
  input logic               clock,
  input logic               reset,
  input logic               flush,
  input logic               ex_stall,
  input logic               stall,
  input logic               split,
  input logic               dec0_valid,
  input logic               dec1_valid,
  input logic               dec0_exception,
  input logic [`XLEN-1:0]   dec0_pc,
  input logic [`XLEN-1:0]   dec1_pc,
  input logic [`XLEN-1:0]   dec0_imm,
  input logic [`XLEN-1:0]   dec1_imm,
  input logic [`REG_AW-1:0] dec0_waddr,
  input logic [`REG_AW-1:0] dec1_waddr
);

  // Synchronous reset empties both slots on the following edge
  assert property (@(posedge clock) !reset |=> !dec0_valid && !dec1_valid)
    else $error("Both slot valids must be low after reset");

  assert property (@(posedge clock) disable iff (!reset) flush |-> !stall && !split)
    else $error("Flush must force stall and split low");

  assert property (@(posedge clock) disable iff (!reset) flush |=> !dec0_valid && !dec1_valid)
    else $error("Flush must leave a bubble in both slots");

  // Execute back-pressure freezes the whole output register
  assert property (@(posedge clock) disable iff (!reset)
    ex_stall && !flush |=> $stable(dec0_valid) && $stable(dec1_valid) &&
      $stable(dec0_pc) && $stable(dec1_pc) && $stable(dec0_imm) && $stable(dec1_imm) &&
      $stable(dec0_waddr) && $stable(dec1_waddr) && $stable(dec0_exception))
    else $error("Outputs changed while execute held the stage");

endmodule

bind decode_top decode_sva u_sva (
  .clock          (clock),
  .reset          (reset),
  .flush          (flush),
  .ex_stall       (ex_stall),
  .stall          (stall),
  .split          (split),
  .dec0_valid     (dec0_valid),
  .dec1_valid     (dec1_valid),
  .dec0_exception (dec0_exception),
  .dec0_pc        (dec0_pc),
  .dec1_pc        (dec1_pc),
  .dec0_imm       (dec0_imm),
  .dec1_imm       (dec1_imm),
  .dec0_waddr     (dec0_waddr),
  .dec1_waddr     (dec1_waddr)
);

`default_nettype wire

// File: sim/decode_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_params.svh"

module decode_tb import decode_pkg::*; ();

  localparam int n_cycles = 400;

  // Expected decode of one word, class flags only count when legal
  typedef struct packed {
    logic             legal;
    logic             basic;
    logic             wren;
    logic             rden1;
    logic             rden2;
    logic             load;
    logic             store;
    logic             branch;
    logic             ecall;
    logic             ebreak;
    logic [`XLEN-1:0] imm;
    alu_op_t          alu;
  } ref_t;

  logic               clock;
  logic               reset;
  logic [`XLEN-1:0]   pc0;
  logic [`XLEN-1:0]   instr0;
  logic [`XLEN-1:0]   pc1;
  logic [`XLEN-1:0]   instr1;
  logic               pair_valid;
  logic               ex_load;
  logic [`REG_AW-1:0] ex_waddr;
  logic               ex_stall;
  logic               flush;
  logic               stall;
  logic               split;
  logic               dec0_valid, dec0_wren, dec0_rden1, dec0_rden2;
  logic               dec0_load, dec0_store, dec0_branch, dec0_exception;
  logic [`XLEN-1:0]   dec0_pc, dec0_imm;
  logic [`REG_AW-1:0] dec0_waddr, dec0_raddr1, dec0_raddr2;
  alu_op_t            dec0_alu_op;
  exc_cause_t         dec0_ecause;
  logic               dec1_valid, dec1_wren, dec1_rden1, dec1_rden2;
  logic               dec1_load, dec1_store, dec1_branch;
  logic [`XLEN-1:0]   dec1_pc, dec1_imm;
  logic [`REG_AW-1:0] dec1_waddr, dec1_raddr1, dec1_raddr2;
  alu_op_t            dec1_alu_op;

  logic [`XLEN-1:0] fetch_pc;
  logic [`XLEN-1:0] fetch_w0;
  logic [`XLEN-1:0] fetch_w1;
  logic             exp_v0;
  logic             exp_v1;
  logic             exp_exc0;
  exc_cause_t       exp_cause0;
  logic [`XLEN-1:0] exp_pc0;
  logic [`XLEN-1:0] exp_pc1;
  logic [`XLEN-1:0] exp_w0;
  logic [`XLEN-1:0] exp_w1;
  ref_t             exp_r0;
  ref_t             exp_r1;
  int               errors;
  int               checks;

  // Register fields get rewritten per draw, SYSTEM words stay as they are
  logic [`XLEN-1:0] encodings [15] = '{
    32'h0050_0093, 32'h0020_81b3, 32'h4020_8233, 32'h0000_a283, 32'h0050_a223,
    32'hfe20_8ee3, 32'h1234_52b7, 32'h0000_1317, 32'h0080_00ef, 32'h0000_80e7,
    32'h4010_d393, 32'h0000_0073, 32'h0010_0073, 32'h0ff0_000f, 32'h0030_7313
  };

  decode_top u_dut (.*);

  always #5 clock = ~clock;

  function automatic alu_op_t ref_alu(input logic [2:0] f3, input logic alt);
    alu_op_t base [8];
    base = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    if (alt && f3 == 3'd0) return ALU_SUB;
    if (alt && f3 == 3'd5) return ALU_SRA;
    return base[f3];
  endfunction

  function automatic ref_t ref_decode(input logic [`XLEN-1:0] w);
    ref_t       r;
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    r = '0;
    r.alu = ALU_ADD;
    case (w[6:0])
      7'b0110111: begin
        {r.legal, r.basic, r.wren} = 3'b111;
        r.imm = {w[31:12], 12'h000};
        r.alu = ALU_PASS_B;
      end
      7'b0010111: begin
        {r.legal, r.basic, r.wren} = 3'b111;
        r.imm = {w[31:12], 12'h000};
      end
      7'b1101111: begin
        {r.legal, r.wren} = 2'b11;
        r.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      7'b1100111: begin
        r.legal = (f3 == 3'd0);
        {r.wren, r.rden1} = 2'b11;
        r.imm = {{20{w[31]}}, w[31:20]};
      end
      7'b1100011: begin
        r.legal = (f3 != 3'd2) && (f3 != 3'd3);
        {r.rden1, r.rden2, r.branch} = 3'b111;
        r.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        r.alu = (f3 < 3'd4) ? ALU_SUB : ((f3 >= 3'd6) ? ALU_SLTU : ALU_SLT); // Compare kind
      end
      7'b0000011: begin
        r.legal = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        {r.wren, r.rden1, r.load} = 3'b111;
        r.imm = {{20{w[31]}}, w[31:20]};
      end
      7'b0100011: begin
        r.legal = (f3 < 3'd3);
        {r.rden1, r.rden2, r.store} = 3'b111;
        r.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      7'b0010011: begin
        r.legal = (f3 == 3'd1) ? (f7 == 7'h00) :
                  ((f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1);
        {r.basic, r.wren, r.rden1} = 3'b111;
        r.imm = {{20{w[31]}}, w[31:20]};
        r.alu = ref_alu(f3, (f3 == 3'd5) && w[30]);
      end
      7'b0110011: begin
        r.legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        {r.basic, r.wren, r.rden1, r.rden2} = 4'b1111;
        r.alu = ref_alu(f3, w[30]);
      end
      7'b0001111: r.legal = (f3 == 3'd0);
      7'b1110011: begin
        r.ecall  = (w == 32'h0000_0073);
        r.ebreak = (w == 32'h0010_0073);
        r.legal  = r.ecall || r.ebreak;
      end
      default: r.legal = 1'b0;
    endcase
    return r;
  endfunction

  function automatic logic reads_target(input logic [`XLEN-1:0] w, input ref_t r,
                                        input logic en, input logic [`REG_AW-1:0] t);
    return en && (t != '0) && ((r.rden1 && w[19:15] == t) || (r.rden2 && w[24:20] == t));
  endfunction

  // Mostly table words with small register numbers so dependencies are common
  function automatic logic [`XLEN-1:0] new_word();
    logic [`XLEN-1:0] w;
    if ($urandom_range(0, 4) == 0) return $urandom();
    w = encodings[$urandom_range(0, 14)];
    if (w[6:0] != 7'b1110011) begin
      w[24:20] = 5'($urandom_range(0, 7));
      w[19:15] = 5'($urandom_range(0, 7));
      w[11:7]  = 5'($urandom_range(0, 7));
    end
    return w;
  endfunction

  task automatic flag_error(input string field);
    errors++;
    $display("[ERROR] %0t ns: %s mismatch", $time, field);
  endtask

  task automatic check_outputs();
    checks++;
    assert (dec0_valid == exp_v0) else flag_error("dec0_valid");
    assert (dec1_valid == exp_v1) else flag_error("dec1_valid");
    assert (dec0_exception == (exp_v0 && exp_exc0)) else flag_error("dec0_exception");
    if (exp_v0) begin
      assert (dec0_pc == exp_pc0) else flag_error("dec0_pc");
      assert (dec0_waddr == exp_w0[11:7]) else flag_error("dec0_waddr");
      assert (dec0_raddr1 == exp_w0[19:15]) else flag_error("dec0_raddr1");
      assert (dec0_raddr2 == exp_w0[24:20]) else flag_error("dec0_raddr2");
      assert (dec0_ecause == exp_cause0) else flag_error("dec0_ecause");
      assert (dec0_wren == (exp_r0.legal && exp_r0.wren)) else flag_error("dec0_wren");
      assert (dec0_rden1 == (exp_r0.legal && exp_r0.rden1)) else flag_error("dec0_rden1");
      assert (dec0_rden2 == (exp_r0.legal && exp_r0.rden2)) else flag_error("dec0_rden2");
      assert (dec0_load == (exp_r0.legal && exp_r0.load)) else flag_error("dec0_load");
      assert (dec0_store == (exp_r0.legal && exp_r0.store)) else flag_error("dec0_store");
      assert (dec0_branch == (exp_r0.legal && exp_r0.branch)) else flag_error("dec0_branch");
      if (exp_r0.legal) begin
        assert (dec0_imm == exp_r0.imm) else flag_error("dec0_imm");
        assert (dec0_alu_op == exp_r0.alu) else flag_error("dec0_alu_op");
      end
    end
    if (exp_v1) begin
      assert (dec1_pc == exp_pc1) else flag_error("dec1_pc");
      assert (dec1_waddr == exp_w1[11:7]) else flag_error("dec1_waddr");
      assert (dec1_raddr1 == exp_w1[19:15]) else flag_error("dec1_raddr1");
      assert (dec1_raddr2 == exp_w1[24:20]) else flag_error("dec1_raddr2");
      assert (dec1_imm == exp_r1.imm) else flag_error("dec1_imm");
      assert (dec1_alu_op == exp_r1.alu) else flag_error("dec1_alu_op");
      assert (dec1_wren == exp_r1.wren) else flag_error("dec1_wren");
      assert (dec1_rden1 == exp_r1.rden1) else flag_error("dec1_rden1");
      assert (dec1_rden2 == exp_r1.rden2) else flag_error("dec1_rden2");
      assert ({dec1_load, dec1_store, dec1_branch} == 3'b000) else flag_error("dec1 class");
    end
  endtask

  task automatic drive_inputs();
    pc0        = fetch_pc;
    instr0     = fetch_w0;
    pc1        = fetch_pc + 4;
    instr1     = fetch_w1;
    pair_valid = ($urandom_range(0, 9) != 0);
    ex_stall   = ($urandom_range(0, 11) == 0);
    flush      = ($urandom_range(0, 19) == 0);
    ex_load    = ($urandom_range(0, 2) == 0);
    case ($urandom_range(0, 2))
      0:       ex_waddr = fetch_w0[19:15];
      1:       ex_waddr = fetch_w1[24:20];
      default: ex_waddr = 5'($urandom_range(0, 7));
    endcase
  endtask

  // Checks stall and split, predicts the next register contents, steps fetch
  task automatic predict();
    ref_t r0;
    ref_t r1;
    logic ok1;
    logic load_use;
    logic raw;
    logic exp_stall;
    logic exp_split;
    r0 = ref_decode(instr0);
    r1 = ref_decode(instr1);
    ok1 = r1.legal && r1.basic;
    load_use = ex_load && (reads_target(instr0, r0, r0.legal && pair_valid, ex_waddr) ||
                           reads_target(instr1, r1, ok1 && pair_valid, ex_waddr));
    exp_stall = !flush && (load_use || ex_stall);
    raw = r0.legal && r0.wren && reads_target(instr1, r1, ok1, instr0[11:7]);
    exp_split = pair_valid && !flush && !exp_stall && (!ok1 || raw);
    assert (stall == exp_stall) else flag_error("stall");
    assert (split == exp_split) else flag_error("split");
    if (flush || !ex_stall) begin
      exp_v0 = pair_valid && !exp_stall && !flush;
      exp_v1 = exp_v0 && ok1 && !exp_split;
      exp_pc0 = pc0;
      exp_pc1 = pc1;
      exp_w0 = instr0;
      exp_w1 = instr1;
      exp_r0 = r0;
      exp_r1 = r1;
      exp_exc0 = !r0.legal || r0.ebreak || r0.ecall;
      exp_cause0 = !r0.legal ? EXC_ILLEGAL : (r0.ebreak ? EXC_BREAKPOINT :
                   (r0.ecall ? EXC_ECALL_M : EXC_NONE));
    end
    if (flush || (pair_valid && !exp_stall && !exp_split)) begin
      fetch_w0 = new_word();
      fetch_w1 = new_word();
      fetch_pc = fetch_pc + 8;
    end else if (exp_split) begin
      fetch_w0 = fetch_w1; // Slot 1 is replayed as the next slot 0
      fetch_w1 = new_word();
      fetch_pc = fetch_pc + 4;
    end
  endtask

  initial begin
    #(n_cycles * 20 * 10);
    $display("Watchdog expired: the run did not finish within the time limit");
    $display("test failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h2ee9));
    clock      = 1'b0;
    reset      = 1'b0;
    pc0        = '0;
    instr0     = `NOP_INSTR;
    pc1        = '0;
    instr1     = `NOP_INSTR;
    pair_valid = 1'b0;
    ex_load    = 1'b0;
    ex_waddr   = '0;
    ex_stall   = 1'b0;
    flush      = 1'b0;
    errors     = 0;
    checks     = 0;
    exp_v0     = 1'b0;
    exp_v1     = 1'b0;
    exp_exc0   = 1'b0;
    fetch_pc   = 32'h0000_1000;
    fetch_w0   = new_word();
    fetch_w1   = new_word();
    repeat (4) @(negedge clock);
    reset = 1'b1;
    for (int cyc = 0; cyc < n_cycles; cyc++) begin
      check_outputs();
      drive_inputs();
      #1;
      predict();
      @(negedge clock);
    end
    check_outputs();
    $display("Checked %0d cycles, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
source/decode_pkg.sv
source/decoder_if.sv
source/int_decoder.sv
source/hazard_unit.sv
source/decode_stage.sv
source/decode_top.sv
sim/decode_sva.sv
sim/decode_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module decode_tb -f list.f -o decode_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/decode_sim > sim.log 2>&1
cat sim.log

grep -qx "test passed" sim.log && echo "Simulation result: PASS" && exit 0 \
  || { echo "Simulation result: FAIL"; exit 1; }
